/* filelist.f */
source/shift_if_pkg.sv
source/shift_regs.sv
source/shift_sequencer.sv
source/shift_lane.sv
source/shift_if_top.sv
tests/tb_shift_if.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f filelist.f --top-module tb_shift_if -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -x "TESTS PASSED" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* tests/tb_shift_if.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_shift_if
    import shift_if_pkg::*;
();

    // Cycles to wait for ack_o, and data register reads while busy
    localparam int ACK_LIMIT  = 16;
    localparam int POLL_LIMIT = 4000;

    logic        clk = 1'b0;
    logic        rst;
    logic        en_i;
    logic        wr_i;
    reg_addr_t   address_i;
    byte_strb_t  wstrb_i;
    reg_word_t   dat_i;
    dev_mask_t   dev_dout_i = '0;
    gpio_vec_t   gpio_i;
    reg_word_t   dat_o;
    logic        ack_o;
    dev_mask_t   dev_clk_o;
    dev_mask_t   dev_din_o;
    dev_mask_t   dev_aux_o;
    dev_mask_t   dev_oe_o;
    gpio_vec_t   gpio_o;
    gpio_vec_t   gpio_oe_o;

    // Register model, GPIO direction comes up as input
    prescale_t   exp_presc    = '0;
    dev_mask_t   exp_hold     = '0;
    dev_mask_t   exp_dev_en   = '0;
    gpio_vec_t   exp_dir      = '1;
    gpio_vec_t   exp_gpio_out = '0;
    shift_byte_t exp_din      = '0;
    shift_byte_t exp_aux      = '0;
    shift_byte_t exp_dout     = '0;
    bit_idx_t    exp_nbit     = '0;
    logic        exp_rev      = 1'b0;
    logic        exp_enseq    = 1'b0;

    // Device model
    // Bits each device returns, and the din/aux seen at every rising clock
    shift_byte_t dout_bits [NUM_DEV];
    int          seq_base  [NUM_DEV];
    logic        seen_din  [NUM_DEV][256];
    logic        seen_aux  [NUM_DEV][256];
    int          rises     [NUM_DEV];
    int          falls     [NUM_DEV];
    int          last_rise [NUM_DEV];
    dev_mask_t   clk_prev = '0;
    int          cyc;

    int          checks;
    int          errors;
    int          mon_checks;
    int          mon_errors;

    always #20 clk = ~clk;

    shift_if_top u_shift_if_top (
        .clk        (clk),
        .rst        (rst),
        .en_i       (en_i),
        .wr_i       (wr_i),
        .address_i  (address_i),
        .wstrb_i    (wstrb_i),
        .dat_i      (dat_i),
        .dev_dout_i (dev_dout_i),
        .gpio_i     (gpio_i),
        .dat_o      (dat_o),
        .ack_o      (ack_o),
        .dev_clk_o  (dev_clk_o),
        .dev_din_o  (dev_din_o),
        .dev_aux_o  (dev_aux_o),
        .dev_oe_o   (dev_oe_o),
        .gpio_o     (gpio_o),
        .gpio_oe_o  (gpio_oe_o)
    );

    // Lane outputs are registered, so they are stable at the falling edge
    always @(negedge clk) begin : device_model
        cyc = cyc + 1;
        for (int d = 0; d < NUM_DEV; d++) begin
            if (dev_clk_o[d] && !clk_prev[d]) begin
                seen_din[d][rises[d] % 256] = dev_din_o[d];
                seen_aux[d][rises[d] % 256] = dev_aux_o[d];
                // Clock period only measured between bits of one sequence
                if (rises[d] != seq_base[d]) begin
                    mon_checks++;
                    assert (cyc - last_rise[d] == 4 * (int'(exp_presc) + 1)) else begin
                        mon_errors++;
                        $display("Error: time %0t, dev_clk_o[%0d] period expected %0d, got %0d",
                                 $time, d, 4 * (int'(exp_presc) + 1), cyc - last_rise[d]);
                    end
                end
                last_rise[d] = cyc;
                rises[d]++;
            end
            if (!dev_clk_o[d] && clk_prev[d]) begin
                mon_checks++;
                assert (cyc - last_rise[d] == 2 * (int'(exp_presc) + 1)) else begin
                    mon_errors++;
                    $display("Error: time %0t, dev_clk_o[%0d] high time expected %0d, got %0d",
                             $time, d, 2 * (int'(exp_presc) + 1), cyc - last_rise[d]);
                end
                falls[d]++;
            end
            clk_prev[d] = dev_clk_o[d];
            // Disabled lanes stay quiet
            if (!exp_dev_en[d]) begin
                mon_checks++;
                assert ({dev_clk_o[d], dev_din_o[d], dev_aux_o[d]} == 3'b000) else begin
                    mon_errors++;
                    $display("Error: time %0t, dev_clk_o/dev_din_o/dev_aux_o[%0d] %s %b",
                             $time, d, "expected 000, got",
                             {dev_clk_o[d], dev_din_o[d], dev_aux_o[d]});
                end
            end
            // Next bit presented after each falling device clock
            dev_dout_i[d] = dout_bits[d][bit_idx_t'(falls[d] - seq_base[d])];
        end
    end

    function automatic shift_byte_t mirror_byte(input shift_byte_t b);
        return {<<{b}};
    endfunction

    function automatic reg_word_t mod_cfg_word();
        reg_word_t w;
        w = '0;
        w[7:0]          = exp_presc;
        w[8 +: NUM_DEV] = exp_hold;
        return w;
    endfunction

    // GPIO input is held stable, so the model reads it straight from the pins
    function automatic reg_word_t dev_cfg_word();
        reg_word_t w;
        w = '0;
        w[0 +: NUM_DEV]   = exp_dev_en;
        w[8 +: NUM_GPIO]  = exp_dir;
        w[16 +: NUM_GPIO] = gpio_i;
        w[24 +: NUM_GPIO] = exp_gpio_out;
        return w;
    endfunction

    // Busy expected clear
    function automatic reg_word_t data_word();
        reg_word_t w;
        w = '0;
        w[7:0]   = exp_din;
        w[15:8]  = exp_aux;
        w[23:16] = exp_dout;
        w[DATA_NBIT_LSB +: 3]  = exp_nbit;
        w[DATA_REVERSE_BIT]    = exp_rev;
        w[DATA_ENSEQ_BIT]      = exp_enseq;
        return w;
    endfunction

    task automatic end_run();
        $display("Checks: %0d, errors: %0d", checks + mon_checks, errors + mon_errors);
        if (errors + mon_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    task automatic check_equal(input string name, input reg_word_t got, input reg_word_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error: time %0t, %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
        end
    endtask

    // Called on a falling edge, holds the request until ack_o, then one more edge
    task automatic bus_access(input logic wr, input reg_addr_t addr, input byte_strb_t strb,
                              input reg_word_t wdata, output reg_word_t rdata);
        int waited;
        en_i      = 1'b1;
        wr_i      = wr;
        address_i = addr;
        wstrb_i   = strb;
        dat_i     = wdata;
        waited    = 0;
        while (!ack_o && waited < ACK_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!ack_o) begin
            $display("Bus access to address %0d was never acknowledged", addr);
            errors++;
            end_run();
        end else begin
            rdata = dat_o;
            // Write commits on this edge, enable and acknowledge both high
            @(negedge clk);
            en_i    = 1'b0;
            wr_i    = 1'b0;
            wstrb_i = '0;
            // Let acknowledge drop before the next access
            @(negedge clk);
        end
    endtask

    task automatic read_reg(input reg_addr_t addr, output reg_word_t rdata);
        bus_access(1'b0, addr, '0, '0, rdata);
    endtask

    task automatic write_reg(input reg_addr_t addr, input byte_strb_t strb, input reg_word_t w);
        reg_word_t unused;
        logic      rev;
        bus_access(1'b1, addr, strb, w, unused);
        // Reverse bit of this same write wins over the stored one
        rev = strb[3] ? w[DATA_REVERSE_BIT] : exp_rev;
        if (addr == ADDR_MOD_CFG) begin
            if (strb[0]) exp_presc = w[7:0];
            if (strb[1]) exp_hold  = w[8 +: NUM_DEV];
        end
        if (addr == ADDR_DEV_CFG) begin
            if (strb[0]) exp_dev_en   = w[0 +: NUM_DEV];
            if (strb[1]) exp_dir      = w[8 +: NUM_GPIO];
            if (strb[3]) exp_gpio_out = w[24 +: NUM_GPIO];
        end
        if (addr == ADDR_DATA) begin
            if (strb[3]) begin
                exp_nbit  = w[DATA_NBIT_LSB +: 3];
                exp_rev   = w[DATA_REVERSE_BIT];
                exp_enseq = w[DATA_ENSEQ_BIT];
            end
            if (strb[1]) exp_aux = w[15:8];
            if (strb[0]) exp_din = rev ? mirror_byte(w[7:0]) : w[7:0];
        end
    endtask

    task automatic check_config();
        reg_word_t rd;
        gpio_vec_t oe;
        oe = ~exp_dir;
        read_reg(ADDR_MOD_CFG, rd);
        check_equal("dat_o module config", rd, mod_cfg_word());
        read_reg(ADDR_DEV_CFG, rd);
        check_equal("dat_o device config", rd, dev_cfg_word());
        read_reg(2'd3, rd);
        check_equal("dat_o address 3", rd, dev_cfg_word());
        check_equal("gpio_o", reg_word_t'(gpio_o), reg_word_t'(exp_gpio_out));
        check_equal("gpio_oe_o", reg_word_t'(gpio_oe_o), reg_word_t'(oe));
        check_equal("dev_oe_o", reg_word_t'(dev_oe_o), reg_word_t'(exp_dev_en | exp_hold));
    endtask

    // Polls busy through data register reads
    task automatic wait_idle();
        reg_word_t rd;
        int        polls;
        read_reg(ADDR_DATA, rd);
        check_equal("busy after start", reg_word_t'(rd[DATA_BUSY_BIT]), 32'd1);
        polls = 0;
        while (rd[DATA_BUSY_BIT] && polls < POLL_LIMIT) begin
            read_reg(ADDR_DATA, rd);
            polls++;
        end
        if (rd[DATA_BUSY_BIT]) begin
            $display("Busy flag never cleared after %0d reads", polls);
            errors++;
            end_run();
        end
    endtask

    // Random prescale, hold-drive and lane enables
    task automatic setup_lanes(input int max_presc);
        reg_word_t w;
        w = $urandom();
        w[7:0] = prescale_t'($urandom_range(0, max_presc));
        write_reg(ADDR_MOD_CFG, 4'b0011, w);
        write_reg(ADDR_DEV_CFG, 4'b0001, $urandom());
    endtask

    // Starts a sequence through a data register write and checks what the devices saw
    task automatic run_shift(input shift_byte_t din, input shift_byte_t aux,
                             input bit_idx_t nbit, input logic rev, input byte_strb_t strb);
        reg_word_t w;
        reg_word_t rd;
        logic      merged;
        int        n;
        for (int d = 0; d < NUM_DEV; d++) begin
            dout_bits[d] = shift_byte_t'($urandom());
            seq_base[d]  = rises[d];
        end
        w = '0;
        w[7:0]  = din;
        w[15:8] = aux;
        w[DATA_NBIT_LSB +: 3] = nbit;
        w[DATA_REVERSE_BIT]   = rev;
        w[DATA_ENSEQ_BIT]     = 1'b1;
        write_reg(ADDR_DATA, strb, w);
        wait_idle();
        n = int'(exp_nbit) + 1;
        // Expected dout is the OR over enabled lanes, upper bits keep old values
        for (int k = 0; k < n; k++) begin
            merged = 1'b0;
            for (int d = 0; d < NUM_DEV; d++) begin
                if (exp_dev_en[d]) merged = merged | dout_bits[d][bit_idx_t'(k)];
            end
            exp_dout[bit_idx_t'(k)] = merged;
        end
        for (int d = 0; d < NUM_DEV; d++) begin
            if (exp_dev_en[d]) begin
                check_equal("dev_clk_o rising edges", reg_word_t'(rises[d] - seq_base[d]),
                            reg_word_t'(n));
                for (int k = 0; k < n; k++) begin
                    check_equal("dev_din_o", reg_word_t'(seen_din[d][(seq_base[d] + k) % 256]),
                                reg_word_t'(exp_din[bit_idx_t'(k)]));
                    check_equal("dev_aux_o", reg_word_t'(seen_aux[d][(seq_base[d] + k) % 256]),
                                reg_word_t'(exp_aux[bit_idx_t'(k)]));
                end
            end else begin
                check_equal("dev_clk_o idle lane", reg_word_t'(rises[d] - seq_base[d]), 32'd0);
            end
        end
        read_reg(ADDR_DATA, rd);
        check_equal("dat_o data", rd, data_word());
    endtask

    initial begin
        reg_word_t rd;
        rst       = 1'b1;
        en_i      = 1'b0;
        wr_i      = 1'b0;
        address_i = '0;
        wstrb_i   = '0;
        dat_i     = '0;
        gpio_i    = '0;
        for (int d = 0; d < NUM_DEV; d++) begin
            dout_bits[d] = '0;
        end
        void'($urandom(4));
        repeat (16) @(negedge clk);
        rst = 1'b0;

        // Reset state
        check_equal("ack_o", reg_word_t'(ack_o), 32'd0);
        check_equal("dev_clk_o", reg_word_t'(dev_clk_o), 32'd0);
        check_equal("dev_din_o", reg_word_t'(dev_din_o), 32'd0);
        check_equal("dev_aux_o", reg_word_t'(dev_aux_o), 32'd0);
        check_equal("dev_oe_o", reg_word_t'(dev_oe_o), 32'd0);
        check_equal("gpio_oe_o", reg_word_t'(gpio_oe_o), 32'd0);
        gpio_i = gpio_vec_t'($urandom());
        @(negedge clk);
        check_config();
        read_reg(ADDR_DATA, rd);
        check_equal("dat_o data", rd, data_word());

        // Random strobes on both config registers
        repeat (24) begin
            write_reg(reg_addr_t'($urandom_range(0, 1)), byte_strb_t'($urandom()), $urandom());
            check_config();
        end

        // GPIO value, direction and input readback, one cycle for the input register
        repeat (4) begin
            write_reg(ADDR_DEV_CFG, 4'b1010, $urandom());
            gpio_i = gpio_vec_t'($urandom());
            @(negedge clk);
            check_config();
        end

        // Plain transfers over random lane masks
        repeat (6) begin
            setup_lanes(3);
            run_shift(shift_byte_t'($urandom()), shift_byte_t'($urandom()),
                      bit_idx_t'($urandom()), 1'b0, 4'hF);
            check_config();
        end

        // Reversed data-out order
        repeat (3) begin
            setup_lanes(3);
            run_shift(shift_byte_t'($urandom()), shift_byte_t'($urandom()),
                      bit_idx_t'($urandom()), 1'b1, 4'hF);
        end

        // Longer prescale, then a restart from a byte 0 write alone
        repeat (2) begin
            setup_lanes(20);
            run_shift(shift_byte_t'($urandom()), shift_byte_t'($urandom()),
                      bit_idx_t'($urandom()), 1'($urandom()), 4'hF);
            run_shift(shift_byte_t'($urandom()), 8'h00, 3'd0, 1'b0, 4'b0001);
        end

        end_run();
    end

endmodule

`default_nettype wire

/* source/shift_if_top.sv */
`timescale 1ns/1ps
`default_nettype none

module shift_if_top
    import shift_if_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire             en_i,
    input  wire             wr_i,
    input  wire reg_addr_t  address_i,
    input  wire byte_strb_t wstrb_i,
    input  wire reg_word_t  dat_i,
    input  wire dev_mask_t  dev_dout_i,
    input  wire gpio_vec_t  gpio_i,
    output reg_word_t       dat_o,
    output logic            ack_o,
    output dev_mask_t       dev_clk_o,
    output dev_mask_t       dev_din_o,
    output dev_mask_t       dev_aux_o,
    output dev_mask_t       dev_oe_o,
    output gpio_vec_t       gpio_o,
    output gpio_vec_t       gpio_oe_o
);

    // Register bank to sequencer
    prescale_t prescale;
    bit_idx_t  nbit_max;
    logic      start;
    logic      busy;
    bit_idx_t  bit_idx;
    logic      out_stb;
    logic      high_stb;
    logic      cap_stb;
    logic      done_stb;

    // Register bank to lanes
    dev_mask_t dev_en;
    dev_mask_t hold_drive;
    logic      din_bit;
    logic      aux_bit;
    dev_mask_t lane_dout;

    shift_regs u_shift_regs (
        .clk          (clk),
        .rst          (rst),
        .en_i         (en_i),
        .wr_i         (wr_i),
        .address_i    (address_i),
        .wstrb_i      (wstrb_i),
        .dat_i        (dat_i),
        .gpio_i       (gpio_i),
        .busy_i       (busy),
        .bit_idx_i    (bit_idx),
        .done_stb_i   (done_stb),
        .lane_dout_i  (lane_dout),
        .dat_o        (dat_o),
        .ack_o        (ack_o),
        .prescale_o   (prescale),
        .nbit_max_o   (nbit_max),
        .start_o      (start),
        .dev_en_o     (dev_en),
        .hold_drive_o (hold_drive),
        .din_bit_o    (din_bit),
        .aux_bit_o    (aux_bit),
        .gpio_o       (gpio_o),
        .gpio_oe_o    (gpio_oe_o)
    );

    shift_sequencer u_shift_sequencer (
        .clk        (clk),
        .rst        (rst),
        .start_i    (start),
        .prescale_i (prescale),
        .nbit_max_i (nbit_max),
        .busy_o     (busy),
        .bit_idx_o  (bit_idx),
        .out_stb_o  (out_stb),
        .high_stb_o (high_stb),
        .cap_stb_o  (cap_stb),
        .done_stb_o (done_stb)
    );

    // One lane per device, all sharing the same strobes and bits
    for (genvar d = 0; d < NUM_DEV; d++) begin : g_lane
        shift_lane u_shift_lane (
            .clk          (clk),
            .rst          (rst),
            .en_i         (dev_en[d]),
            .hold_drive_i (hold_drive[d]),
            .din_bit_i    (din_bit),
            .aux_bit_i    (aux_bit),
            .out_stb_i    (out_stb),
            .high_stb_i   (high_stb),
            .cap_stb_i    (cap_stb),
            .done_stb_i   (done_stb),
            .dev_dout_i   (dev_dout_i[d]),
            .dev_clk_o    (dev_clk_o[d]),
            .dev_din_o    (dev_din_o[d]),
            .dev_aux_o    (dev_aux_o[d]),
            .dev_oe_o     (dev_oe_o[d]),
            .dout_bit_o   (lane_dout[d])
        );
    end

endmodule

`default_nettype wire

/* source/shift_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module shift_lane (
    input  wire  clk,
    input  wire  rst,
    input  wire  en_i,
    input  wire  hold_drive_i,
    input  wire  din_bit_i,
    input  wire  aux_bit_i,
    input  wire  out_stb_i,
    input  wire  high_stb_i,
    input  wire  cap_stb_i,
    input  wire  done_stb_i,
    input  wire  dev_dout_i,
    output logic dev_clk_o,
    output logic dev_din_o,
    output logic dev_aux_o,
    output logic dev_oe_o,
    output logic dout_bit_o
);

    // Pin registers, one per device line
    logic clk_q;
    logic din_q;
    logic aux_q;
    // Sampled data-in, held until the done phase picks it up
    logic cap_q;

    // Device clock
    // Rises after the high phase, falls after the done phase
    always_ff @(posedge clk) begin
        if (rst || !en_i) begin
            clk_q <= 1'b0;
        end else if (high_stb_i) begin
            clk_q <= 1'b1;
        end else if (done_stb_i) begin
            clk_q <= 1'b0;
        end
    end

    // Data and aux change while the device clock is low
    always_ff @(posedge clk) begin
        if (rst || !en_i) begin
            din_q <= 1'b0;
            aux_q <= 1'b0;
        end else if (out_stb_i) begin
            din_q <= din_bit_i;
            aux_q <= aux_bit_i;
        end
    end

    // Sample mid high time
    always_ff @(posedge clk) begin
        if (rst || !en_i) begin
            cap_q <= 1'b0;
        end else if (cap_stb_i) begin
            cap_q <= dev_dout_i;
        end
    end

    assign dev_clk_o  = clk_q;
    assign dev_din_o  = din_q;
    assign dev_aux_o  = aux_q;
    // Pins driven while enabled, or idle-low with hold drive set
    assign dev_oe_o   = en_i | hold_drive_i;
    // Disabled lane contributes 0 to the merged dout
    assign dout_bit_o = cap_q;

endmodule

`default_nettype wire

/* source/shift_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module shift_sequencer
    import shift_if_pkg::*;
(
    input  wire            clk,
    input  wire            rst,
    input  wire            start_i,
    input  wire prescale_t prescale_i,
    input  wire bit_idx_t  nbit_max_i,
    output logic           busy_o,
    output bit_idx_t       bit_idx_o,
    output logic           out_stb_o,
    output logic           high_stb_o,
    output logic           cap_stb_o,
    output logic           done_stb_o
);

    bit_phase_e phase_q;
    prescale_t  presc_cnt_q;
    bit_idx_t   bit_idx_q;
    logic       busy;
    logic       tick;
    logic       last_bit;

    // Any phase other than idle means a sequence is running
    assign busy     = (phase_q != PH_IDLE);
    // One tick per prescale+1 cycles while running
    assign tick     = busy && (presc_cnt_q == prescale_i);
    assign last_bit = (bit_idx_q == nbit_max_i);

    // Prescaler, held at zero while idle so each phase starts clean
    always_ff @(posedge clk) begin
        if (rst) begin
            presc_cnt_q <= '0;
        end else if (!busy || tick) begin
            presc_cnt_q <= '0;
        end else begin
            presc_cnt_q <= presc_cnt_q + 8'd1;
        end
    end

    // Phase machine and bit counter
    always_ff @(posedge clk) begin
        if (rst) begin
            phase_q   <= PH_IDLE;
            bit_idx_q <= '0;
        end else begin
            case (phase_q)
                PH_IDLE: begin
                    // Start only honored here, so a start while busy is dropped
                    if (start_i) begin
                        phase_q   <= PH_OUTPUT;
                        bit_idx_q <= '0;
                    end
                end
                PH_OUTPUT: begin
                    if (tick) phase_q <= PH_HIGH;
                end
                PH_HIGH: begin
                    if (tick) phase_q <= PH_CAPTURE;
                end
                PH_CAPTURE: begin
                    if (tick) phase_q <= PH_DONE;
                end
                PH_DONE: begin
                    if (tick) begin
                        if (last_bit) begin
                            phase_q <= PH_IDLE;
                        end else begin
                            phase_q   <= PH_OUTPUT;
                            bit_idx_q <= bit_idx_q + 3'd1;
                        end
                    end
                end
                default: begin
                    phase_q <= PH_IDLE;
                end
            endcase
        end
    end

    assign busy_o     = busy;
    assign bit_idx_o  = bit_idx_q;
    // Strobes fire in the last cycle of their phase
    assign out_stb_o  = tick && (phase_q == PH_OUTPUT);
    assign high_stb_o = tick && (phase_q == PH_HIGH);
    assign cap_stb_o  = tick && (phase_q == PH_CAPTURE);
    assign done_stb_o = tick && (phase_q == PH_DONE);

endmodule

`default_nettype wire

/* source/shift_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module shift_regs
    import shift_if_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire             en_i,
    input  wire             wr_i,
    input  wire reg_addr_t  address_i,
    input  wire byte_strb_t wstrb_i,
    input  wire reg_word_t  dat_i,
    input  wire gpio_vec_t  gpio_i,
    input  wire             busy_i,
    input  wire bit_idx_t   bit_idx_i,
    input  wire             done_stb_i,
    input  wire dev_mask_t  lane_dout_i,
    output reg_word_t       dat_o,
    output logic            ack_o,
    output prescale_t       prescale_o,
    output bit_idx_t        nbit_max_o,
    output logic            start_o,
    output dev_mask_t       dev_en_o,
    output dev_mask_t       hold_drive_o,
    output logic            din_bit_o,
    output logic            aux_bit_o,
    output gpio_vec_t       gpio_o,
    output gpio_vec_t       gpio_oe_o
);

    // Bus side
    logic        ack_q;
    reg_word_t   rd_data_q;
    reg_word_t   rd_mux;
    logic        wr_commit;

    // Module and device config fields
    prescale_t   prescale_q;
    dev_mask_t   hold_drive_q;
    dev_mask_t   dev_en_q;
    gpio_vec_t   gpio_dir_q;
    gpio_vec_t   gpio_out_q;
    gpio_vec_t   gpio_in_q;

    // Data register fields
    shift_byte_t din_q;
    shift_byte_t aux_q;
    shift_byte_t dout_q;
    bit_idx_t    nbit_max_q;
    logic        reverse_q;
    logic        enseq_q;

    // Effective control bits for the current write
    logic        din_rev;
    logic        seq_req;

    function automatic shift_byte_t reverse_byte(input shift_byte_t b);
        shift_byte_t r;
        for (int i = 0; i < 8; i++) begin
            r[i] = b[7-i];
        end
        return r;
    endfunction

    // Acknowledge trails enable by one cycle, write lands while both are high
    assign wr_commit = en_i && ack_q && wr_i;

    // Byte 3 in the same access overrides the stored control bits
    assign din_rev = wstrb_i[3] ? dat_i[DATA_REVERSE_BIT] : reverse_q;
    assign seq_req = wstrb_i[3] ? dat_i[DATA_ENSEQ_BIT] : enseq_q;

    always_comb begin
        rd_mux = '0;
        case (address_i)
            ADDR_MOD_CFG: begin
                rd_mux[7:0]          = prescale_q;
                rd_mux[8 +: NUM_DEV] = hold_drive_q;
            end
            ADDR_DATA: begin
                rd_mux[7:0]   = din_q;
                rd_mux[15:8]  = aux_q;
                rd_mux[23:16] = dout_q;
                rd_mux[DATA_NBIT_LSB +: $bits(bit_idx_t)] = nbit_max_q;
                rd_mux[DATA_REVERSE_BIT] = reverse_q;
                rd_mux[DATA_ENSEQ_BIT]   = enseq_q;
                rd_mux[DATA_BUSY_BIT]    = busy_i;
            end
            // Device config, address 3 lands here as well
            default: begin
                rd_mux[0 +: NUM_DEV]   = dev_en_q;
                rd_mux[8 +: NUM_GPIO]  = gpio_dir_q;
                rd_mux[16 +: NUM_GPIO] = gpio_in_q;
                rd_mux[24 +: NUM_GPIO] = gpio_out_q;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q     <= 1'b0;
            rd_data_q <= '0;
            gpio_in_q <= '0;
        end else begin
            ack_q     <= en_i;
            gpio_in_q <= gpio_i;
            // Read data refreshed on every enabled non-write cycle
            if (en_i && !wr_i) begin
                rd_data_q <= rd_mux;
            end
        end
    end

    // Config registers
    always_ff @(posedge clk) begin
        if (rst) begin
            prescale_q   <= '0;
            hold_drive_q <= '0;
            dev_en_q     <= '0;
            // GPIOs come up as inputs
            gpio_dir_q   <= '1;
            gpio_out_q   <= '0;
        end else if (wr_commit) begin
            if (address_i == ADDR_MOD_CFG) begin
                if (wstrb_i[0]) prescale_q   <= dat_i[7:0];
                if (wstrb_i[1]) hold_drive_q <= dat_i[8 +: NUM_DEV];
            end
            if (address_i == ADDR_DEV_CFG) begin
                if (wstrb_i[0]) dev_en_q   <= dat_i[0 +: NUM_DEV];
                if (wstrb_i[1]) gpio_dir_q <= dat_i[8 +: NUM_GPIO];
                if (wstrb_i[3]) gpio_out_q <= dat_i[24 +: NUM_GPIO];
            end
        end
    end

    // Data register and dout assembly
    always_ff @(posedge clk) begin
        if (rst) begin
            din_q      <= '0;
            aux_q      <= '0;
            dout_q     <= '0;
            nbit_max_q <= '0;
            reverse_q  <= 1'b0;
            enseq_q    <= 1'b0;
        end else begin
            if (wr_commit && (address_i == ADDR_DATA)) begin
                if (wstrb_i[3]) begin
                    nbit_max_q <= dat_i[DATA_NBIT_LSB +: $bits(bit_idx_t)];
                    reverse_q  <= dat_i[DATA_REVERSE_BIT];
                    enseq_q    <= dat_i[DATA_ENSEQ_BIT];
                end
                // Aux is never reversed
                if (wstrb_i[1]) aux_q <= dat_i[15:8];
                if (wstrb_i[0]) begin
                    din_q <= din_rev ? reverse_byte(dat_i[7:0]) : dat_i[7:0];
                end
            end
            // Captured bits of all enabled lanes merged into one byte
            if (done_stb_i) begin
                dout_q[bit_idx_i] <= |lane_dout_i;
            end
        end
    end

    assign dat_o        = rd_data_q;
    assign ack_o        = ack_q;
    assign prescale_o   = prescale_q;
    assign nbit_max_o   = nbit_max_q;
    // Sequence start on the commit edge of a data register write
    assign start_o      = wr_commit && (address_i == ADDR_DATA) && seq_req;
    assign dev_en_o     = dev_en_q;
    assign hold_drive_o = hold_drive_q;
    // Current bit shared by every lane
    assign din_bit_o    = din_q[bit_idx_i];
    assign aux_bit_o    = aux_q[bit_idx_i];
    assign gpio_o       = gpio_out_q;
    // Direction bit 1 means input
    assign gpio_oe_o    = ~gpio_dir_q;

endmodule

`default_nettype wire

/* source/shift_if_pkg.sv */
`default_nettype none

package shift_if_pkg;

    // Device lanes and GPIO pins, each at most 8
    localparam int NUM_DEV  = 4;
    localparam int NUM_GPIO = 4;

    // Host register port
    typedef logic [31:0] reg_word_t;
    typedef logic [1:0]  reg_addr_t;
    typedef logic [3:0]  byte_strb_t;

    // Shift data byte, used for din, aux and dout
    typedef logic [7:0] shift_byte_t;
    // Bit index within a byte, also the bit count minus one
    typedef logic [2:0] bit_idx_t;
    // Prescaler reload value
    typedef logic [7:0] prescale_t;

    // One bit per device lane or GPIO pin
    typedef logic [NUM_DEV-1:0]  dev_mask_t;
    typedef logic [NUM_GPIO-1:0] gpio_vec_t;

    // Register map
    // Address 3 is not decoded and reads back as the device config
    localparam reg_addr_t ADDR_MOD_CFG = 2'd0;
    localparam reg_addr_t ADDR_DEV_CFG = 2'd1;
    localparam reg_addr_t ADDR_DATA    = 2'd2;

    // Data register control byte
    // Bits 28:27 are reserved and read as 0
    localparam int DATA_NBIT_LSB    = 24;
    localparam int DATA_REVERSE_BIT = 29;
    localparam int DATA_ENSEQ_BIT   = 30;
    localparam int DATA_BUSY_BIT    = 31;

    // Four phases per bit, idle between sequences
    // OUTPUT presents data, HIGH raises the device clock,
    // CAPTURE samples data-in, DONE lowers the clock again
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_OUTPUT,
        PH_HIGH,
        PH_CAPTURE,
        PH_DONE
    } bit_phase_e;

endpackage

`default_nettype wire
